/* usb_in_pkg.sv */
/* USB IN path shared definitions
   PID codes, endpoint and packet widths, handshake timeout */

`default_nettype none

package usb_in_pkg;

  //////////////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////////////

  localparam int NUM_IN_EPS         = 4;   // Implemented IN endpoints
  localparam int MAX_PKT_BYTES      = 16;  // Buffer bytes per endpoint
  localparam int EP_IDX_W           = $clog2(NUM_IN_EPS);
  localparam int PKT_ADDR_W         = $clog2(MAX_PKT_BYTES);

  // About 18 bit times at 4 clocks per bit
  localparam int ACK_TIMEOUT_CYCLES = 73;
  localparam int ACK_CNT_W          = $clog2(ACK_TIMEOUT_CYCLES + 1);

  //////////////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////////////

  typedef logic [3:0]              ep_num_t;    // Endpoint field of a token
  typedef logic [EP_IDX_W-1:0]     ep_idx_t;    // Implemented endpoint only
  typedef logic [6:0]              dev_addr_t;
  typedef logic [PKT_ADDR_W-1:0]   pkt_addr_t;  // Byte offset in a packet
  typedef logic [PKT_ADDR_W:0]     pkt_len_t;   // 0 to MAX_PKT_BYTES
  typedef logic [NUM_IN_EPS-1:0]   ep_mask_t;   // One flag per endpoint
  typedef logic [ACK_CNT_W-1:0]    ack_cnt_t;
  typedef logic [3:0]              pid_t;       // Raw PID as on the ports

  // Low two bits give the PID type, upper two the subtype
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110
  } usb_pid_e;

endpackage

`default_nettype wire

/* usb_rx_pkt_if.sv */
/* Received packet bundle
   Decoded fields and strobes from the packet decoder */

`timescale 1ns/10ps
`default_nettype none

interface usb_rx_pkt_if;

  logic                   pkt_start;  // Start of a received packet
  logic                   pkt_end;    // Reception finished
  logic                   pkt_valid;  // Qualifies pkt_end
  usb_in_pkg::pid_t       pid;        // Fields of the most recent packet
  usb_in_pkg::dev_addr_t  addr;
  usb_in_pkg::ep_num_t    endp;

  // Top level side
  modport src (
    output pkt_start, pkt_end, pkt_valid, pid, addr, endp
  );

  // Protocol engine side
  modport pe (
    input  pkt_start, pkt_end, pkt_valid, pid, addr, endp
  );

endinterface

`default_nettype wire

/* usb_in_ep_if.sv */
/* Engine to endpoint buffer link
   Endpoint select, byte fetch and transaction outcome */

`timescale 1ns/10ps
`default_nettype none

interface usb_in_ep_if;

  // Driven by the engine
  usb_in_pkg::ep_idx_t    cur_ep;     // Endpoint of the running transaction
  logic                   newpkt;     // New IN transaction started
  usb_in_pkg::pkt_addr_t  get_addr;   // Offset of the next byte
  logic                   xact_end;   // Host ACKed the packet
  logic                   rollback;   // Transaction failed, keep packet

  // Driven by the buffer
  usb_in_pkg::ep_mask_t   enabled;
  usb_in_pkg::ep_mask_t   stall;
  usb_in_pkg::ep_mask_t   has_data;   // Packet ready per endpoint
  logic [7:0]             data;       // Byte at cur_ep and get_addr
  logic                   data_done;  // get_addr reached packet length

  modport pe (
    output cur_ep, newpkt, get_addr, xact_end, rollback,
    input  enabled, stall, has_data, data, data_done
  );

  modport ep_buf (
    input  cur_ep, newpkt, get_addr, xact_end, rollback,
    output enabled, stall, has_data, data, data_done
  );

endinterface

`default_nettype wire

/* usb_in_pe.sv */
/* USB full-speed IN protocol engine
   Answers IN tokens with DATA0/1, NAK or STALL, streams the payload to the
   transmitter and waits a bounded time for the host handshake */

`timescale 1ns/10ps
`default_nettype none

module usb_in_pe (
  input  logic                   clk_48mhz_i,
  input  logic                   rst_ni,
  input  logic                   link_reset_i,    // Bus reset seen on the link
  input  usb_in_pkg::dev_addr_t  dev_addr_i,
  usb_rx_pkt_if.pe               rx_i,
  usb_in_ep_if.pe                ep_o,
  output logic                   tx_pkt_start_o,  // Send a packet now
  output usb_in_pkg::pid_t       tx_pid_o,
  input  logic                   tx_pkt_end_i,    // Packet has left the PHY
  output logic                   tx_data_avail_o,
  input  logic                   tx_data_get_i,   // Transmitter took tx_data_o
  output logic [7:0]             tx_data_o,
  output usb_in_pkg::ep_mask_t   in_data_toggle_o,
  output logic                   event_timeout_o, // No handshake in time
  output logic                   event_nak_o      // Host NAKed our data
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RCVD_IN,        // Token accepted, pick a response
    ST_SEND_DATA,      // Payload streaming
    ST_WAIT_TX_END,
    ST_WAIT_HS_START,  // Timeout running
    ST_WAIT_HS
  } in_state_e;

  in_state_e state_q, state_d;

  //////////////////////////////////////////////////////////////////////////////
  // Token and handshake decode
  //////////////////////////////////////////////////////////////////////////////

  logic                  token_rcvd, in_token_rcvd, setup_token_rcvd;
  logic                  ack_rcvd, nak_rcvd;
  logic                  ep_in_hw, ep_active, in_starting;
  usb_in_pkg::ep_idx_t   ep_idx_d;  // Index taken from the token

  assign token_rcvd       = rx_i.pkt_end && rx_i.pkt_valid && (rx_i.addr == dev_addr_i);
  assign in_token_rcvd    = token_rcvd && (rx_i.pid == usb_in_pkg::PID_IN);
  assign setup_token_rcvd = token_rcvd && (rx_i.pid == usb_in_pkg::PID_SETUP);
  assign ack_rcvd = rx_i.pkt_end && rx_i.pkt_valid && (rx_i.pid == usb_in_pkg::PID_ACK);
  assign nak_rcvd = rx_i.pkt_end && rx_i.pkt_valid && (rx_i.pid == usb_in_pkg::PID_NAK);

  // Endpoint numbers past the last implemented one are ignored
  assign ep_in_hw  = rx_i.endp < usb_in_pkg::ep_num_t'(usb_in_pkg::NUM_IN_EPS);
  assign ep_idx_d  = rx_i.endp[usb_in_pkg::EP_IDX_W-1:0];
  assign ep_active = ep_in_hw && ep_o.enabled[ep_idx_d];

  // A new IN is only taken between transactions or in place of a handshake
  assign in_starting = in_token_rcvd && (state_q == ST_IDLE || state_q == ST_WAIT_HS);

  //////////////////////////////////////////////////////////////////////////////
  // Transaction capture
  //////////////////////////////////////////////////////////////////////////////

  usb_in_pkg::ep_idx_t   cur_ep_q;
  logic                  newpkt_q;
  logic                  has_data_q;  // Packet was ready at token time

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cur_ep_q   <= '0;
      newpkt_q   <= 1'b0;
      has_data_q <= 1'b0;
    end else begin
      newpkt_q <= in_starting && ep_in_hw;  // One cycle pulse
      if (in_starting && ep_in_hw) begin
        cur_ep_q   <= ep_idx_d;
        has_data_q <= ep_o.has_data[ep_idx_d];
      end
    end
  end

  logic more_data;
  logic last_get;  // Byte at the top offset taken

  assign more_data       = has_data_q && !ep_o.data_done;
  assign tx_data_avail_o = (state_q == ST_SEND_DATA) && more_data;
  assign last_get        = tx_data_get_i && (&ep_o.get_addr);

  //////////////////////////////////////////////////////////////////////////////
  // Transaction FSM
  //////////////////////////////////////////////////////////////////////////////

  usb_in_pkg::ep_mask_t  toggle_q, toggle_d;
  usb_in_pkg::ack_cnt_t  cnt_q, cnt_d;
  logic                  xact_end, rollback;

  always_comb begin
    state_d        = state_q;
    tx_pkt_start_o = 1'b0;
    tx_pid_o       = usb_in_pkg::PID_NAK;
    xact_end       = 1'b0;
    rollback       = 1'b0;
    cnt_d          = usb_in_pkg::ack_cnt_t'(usb_in_pkg::ACK_TIMEOUT_CYCLES);  // Reload
    unique case (state_q)
      ST_IDLE: begin
        if (in_starting && ep_active) state_d = ST_RCVD_IN;  // Silent otherwise
      end
      ST_RCVD_IN: begin
        tx_pkt_start_o = 1'b1;
        if (ep_o.stall[cur_ep_q]) begin
          tx_pid_o = usb_in_pkg::PID_STALL;
          state_d  = ST_IDLE;
        end else if (has_data_q) begin
          tx_pid_o = toggle_q[cur_ep_q] ? usb_in_pkg::PID_DATA1 : usb_in_pkg::PID_DATA0;
          state_d  = ST_SEND_DATA;
        end else begin
          state_d  = ST_IDLE;  // NAK, nothing loaded
        end
      end
      ST_SEND_DATA: begin
        if (!more_data || last_get) begin
          state_d = tx_pkt_end_i ? ST_WAIT_HS_START : ST_WAIT_TX_END;
        end
      end
      ST_WAIT_TX_END: begin
        if (tx_pkt_end_i) state_d = ST_WAIT_HS_START;
      end
      ST_WAIT_HS_START: begin
        cnt_d = cnt_q - 1'b1;
        if (rx_i.pkt_start) begin
          state_d = ST_WAIT_HS;
        end else if (cnt_q == '0) begin
          state_d  = ST_IDLE;  // Host never answered
          rollback = 1'b1;
        end
      end
      ST_WAIT_HS: begin
        if (ack_rcvd) begin
          state_d  = ST_IDLE;
          xact_end = 1'b1;
        end else if (in_starting) begin
          // Handshake lost, host is already retrying
          state_d  = ep_active ? ST_RCVD_IN : ST_IDLE;
          rollback = 1'b1;
        end else if (rx_i.pkt_end) begin
          state_d  = ST_IDLE;  // NAK or any other packet
          rollback = 1'b1;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      cnt_q   <= usb_in_pkg::ack_cnt_t'(usb_in_pkg::ACK_TIMEOUT_CYCLES);
    end else if (link_reset_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= usb_in_pkg::ack_cnt_t'(usb_in_pkg::ACK_TIMEOUT_CYCLES);
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Offset restarts for every response so a retry resends from byte 0
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ep_o.get_addr <= '0;
    end else if (state_q == ST_IDLE || state_q == ST_RCVD_IN) begin
      ep_o.get_addr <= '0;
    end else if (state_q == ST_SEND_DATA && tx_data_get_i) begin
      ep_o.get_addr <= ep_o.get_addr + 1'b1;
    end
  end

  // One cycle behind get_addr
  always_ff @(posedge clk_48mhz_i) begin
    tx_data_o <= ep_o.data;
  end

  //////////////////////////////////////////////////////////////////////////////
  // Data toggles
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    toggle_d = toggle_q;
    if (setup_token_rcvd && ep_active) begin
      toggle_d[ep_idx_d] = 1'b1;  // Data stage after SETUP starts with DATA1
    end else if (xact_end) begin
      toggle_d[cur_ep_q] = ~toggle_q[cur_ep_q];
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      toggle_q <= '0;
    end else if (link_reset_i) begin
      toggle_q <= '0;  // All endpoints back to DATA0
    end else begin
      toggle_q <= toggle_d;
    end
  end

  assign in_data_toggle_o = toggle_q;

  // Buffer side
  assign ep_o.cur_ep   = cur_ep_q;
  assign ep_o.newpkt   = newpkt_q;
  assign ep_o.xact_end = xact_end;
  assign ep_o.rollback = rollback;

  // Events
  assign event_timeout_o = rollback && (state_q == ST_WAIT_HS_START);
  assign event_nak_o     = nak_rcvd && (state_q == ST_WAIT_HS);

  state_legal_a : assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    state_q inside {ST_IDLE, ST_RCVD_IN, ST_SEND_DATA, ST_WAIT_TX_END,
                    ST_WAIT_HS_START, ST_WAIT_HS});

  // A response only follows an accepted IN token of the previous cycle
  pkt_start_in_rcvd_a : assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    tx_pkt_start_o |-> (state_q == ST_RCVD_IN) && $past(in_token_rcvd && ep_active));

endmodule

`default_nettype wire

/* usb_in_ep_buf.sv */
/* IN endpoint packet buffer
   One packet per endpoint, ready flags, enable and stall config,
   combinational byte fetch for the protocol engine */

`timescale 1ns/10ps
`default_nettype none

module usb_in_ep_buf (
  input  logic                   clk_48mhz_i,
  input  logic                   rst_ni,
  input  logic                   wr_en_i,      // Software byte write
  input  usb_in_pkg::ep_idx_t    wr_ep_i,
  input  usb_in_pkg::pkt_addr_t  wr_addr_i,
  input  logic [7:0]             wr_data_i,
  input  logic                   set_ready_i,  // Mark a packet ready
  input  usb_in_pkg::ep_idx_t    set_ep_i,
  input  usb_in_pkg::pkt_len_t   set_len_i,
  input  usb_in_pkg::ep_mask_t   ep_enable_i,
  input  usb_in_pkg::ep_mask_t   ep_stall_i,
  usb_in_ep_if.ep_buf            buf_o,
  output usb_in_pkg::ep_mask_t   in_sent_o     // Packet delivered and ACKed
);

  //////////////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////////////

  logic [7:0]            mem_q [usb_in_pkg::NUM_IN_EPS][usb_in_pkg::MAX_PKT_BYTES];
  usb_in_pkg::pkt_len_t  len_q [usb_in_pkg::NUM_IN_EPS];
  usb_in_pkg::ep_mask_t  ready_q;
  usb_in_pkg::ep_mask_t  enable_q, stall_q;
  usb_in_pkg::ep_mask_t  in_sent_q;
  logic                  inflight_q;  // Current transaction carries our packet
  logic                  sent;

  assign sent = buf_o.xact_end && inflight_q;

  always_ff @(posedge clk_48mhz_i) begin
    if (wr_en_i) mem_q[wr_ep_i][wr_addr_i] <= wr_data_i;
  end

  // Ready flags and lengths
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_q <= '0;
      len_q   <= '{default: '0};
    end else begin
      if (sent) ready_q[buf_o.cur_ep] <= 1'b0;  // Packet consumed
      if (set_ready_i) begin                    // Software load wins
        ready_q[set_ep_i] <= 1'b1;
        len_q[set_ep_i]   <= set_len_i;
      end
    end
  end

  // Endpoint configuration, all disabled out of reset
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= '0;
      stall_q  <= '0;
    end else begin
      enable_q <= ep_enable_i;
      stall_q  <= ep_stall_i;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Transaction tracking
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else if (buf_o.newpkt) begin
      // Engine answers with data only for a ready, unstalled endpoint
      inflight_q <= ready_q[buf_o.cur_ep] && !stall_q[buf_o.cur_ep];
    end else if (buf_o.xact_end || buf_o.rollback) begin
      inflight_q <= 1'b0;  // Rollback keeps the packet for the retry
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_sent_q <= '0;
    end else begin
      in_sent_q <= sent ? usb_in_pkg::ep_mask_t'(1) << buf_o.cur_ep : '0;
    end
  end

  assign in_sent_o = in_sent_q;

  // Engine side
  assign buf_o.enabled   = enable_q;
  assign buf_o.stall     = stall_q;
  assign buf_o.has_data  = ready_q;
  assign buf_o.data      = mem_q[buf_o.cur_ep][buf_o.get_addr];
  assign buf_o.data_done = usb_in_pkg::pkt_len_t'(buf_o.get_addr) == len_q[buf_o.cur_ep];

  set_len_max_a : assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    set_ready_i |-> set_len_i <= usb_in_pkg::pkt_len_t'(usb_in_pkg::MAX_PKT_BYTES));

  // Engine only completes a transaction that started with this packet
  xact_end_inflight_a : assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    buf_o.xact_end |-> inflight_q);

endmodule

`default_nettype wire

/* usb_in_top.sv */
/* USB IN path top level
   Bundles the decoder ports and links the engine with the packet buffer */

`timescale 1ns/10ps
`default_nettype none

module usb_in_top (
  input  logic                   clk_48mhz_i,
  input  logic                   rst_ni,
  input  logic                   link_reset_i,
  input  usb_in_pkg::dev_addr_t  dev_addr_i,
  // Packet decoder
  input  logic                   rx_pkt_start_i,
  input  logic                   rx_pkt_end_i,
  input  logic                   rx_pkt_valid_i,
  input  usb_in_pkg::pid_t       rx_pid_i,
  input  usb_in_pkg::dev_addr_t  rx_addr_i,
  input  usb_in_pkg::ep_num_t    rx_endp_i,
  // Packet encoder
  output logic                   tx_pkt_start_o,
  output usb_in_pkg::pid_t       tx_pid_o,
  input  logic                   tx_pkt_end_i,
  output logic                   tx_data_avail_o,
  input  logic                   tx_data_get_i,
  output logic [7:0]             tx_data_o,
  // Status and events
  output usb_in_pkg::ep_mask_t   in_data_toggle_o,
  output logic                   event_timeout_o,
  output logic                   event_nak_o,
  output usb_in_pkg::ep_mask_t   in_sent_o,
  // Software side of the buffer
  input  logic                   wr_en_i,
  input  usb_in_pkg::ep_idx_t    wr_ep_i,
  input  usb_in_pkg::pkt_addr_t  wr_addr_i,
  input  logic [7:0]             wr_data_i,
  input  logic                   set_ready_i,
  input  usb_in_pkg::ep_idx_t    set_ep_i,
  input  usb_in_pkg::pkt_len_t   set_len_i,
  input  usb_in_pkg::ep_mask_t   ep_enable_i,
  input  usb_in_pkg::ep_mask_t   ep_stall_i
);

  usb_rx_pkt_if rx_if ();
  usb_in_ep_if  ep_if ();

  assign rx_if.pkt_start = rx_pkt_start_i;
  assign rx_if.pkt_end   = rx_pkt_end_i;
  assign rx_if.pkt_valid = rx_pkt_valid_i;
  assign rx_if.pid       = rx_pid_i;
  assign rx_if.addr      = rx_addr_i;
  assign rx_if.endp      = rx_endp_i;

  usb_in_pe u_pe (
    .clk_48mhz_i, .rst_ni, .link_reset_i, .dev_addr_i,
    .rx_i (rx_if.pe),
    .ep_o (ep_if.pe),
    .tx_pkt_start_o, .tx_pid_o, .tx_pkt_end_i,
    .tx_data_avail_o, .tx_data_get_i, .tx_data_o,
    .in_data_toggle_o, .event_timeout_o, .event_nak_o
  );

  usb_in_ep_buf u_buf (
    .clk_48mhz_i, .rst_ni,
    .wr_en_i, .wr_ep_i, .wr_addr_i, .wr_data_i,
    .set_ready_i, .set_ep_i, .set_len_i,
    .ep_enable_i, .ep_stall_i,
    .buf_o (ep_if.ep_buf),
    .in_sent_o
  );

endmodule

`default_nettype wire

/* tb_usb_in_host.svh */
/* Host and transmitter models
   Token and handshake packets from the host, payload draining by the encoder */

`ifndef TB_USB_IN_HOST_SVH
`define TB_USB_IN_HOST_SVH

  // Received packet whose reception ends two cycles after its start
  task automatic send_token(input usb_in_pkg::usb_pid_e pid,
                            input usb_in_pkg::dev_addr_t addr,
                            input usb_in_pkg::ep_num_t endp);
    @(posedge clk_48mhz_i);
    rx_pkt_start_i <= 1'b1;
    rx_pid_i       <= pid;
    rx_addr_i      <= addr;
    rx_endp_i      <= endp;
    @(posedge clk_48mhz_i);
    rx_pkt_start_i <= 1'b0;
    @(posedge clk_48mhz_i);
    rx_pkt_end_i   <= 1'b1;  // Valid CRC
    rx_pkt_valid_i <= 1'b1;
    @(posedge clk_48mhz_i);
    rx_pkt_end_i   <= 1'b0;
    rx_pkt_valid_i <= 1'b0;
  endtask

  // Handshakes carry no address or endpoint
  task automatic send_handshake(input usb_in_pkg::usb_pid_e pid);
    send_token(pid, '0, '0);
  endtask

  // Encoder side of a DATA packet
  task automatic consume_packet();
    repeat (2) @(posedge clk_48mhz_i);  // First byte settles in tx_data_o
    @(negedge clk_48mhz_i);
    while (tx_data_avail_o) begin
      @(posedge clk_48mhz_i);
      tx_data_get_i <= 1'b1;
      @(posedge clk_48mhz_i);
      tx_data_get_i <= 1'b0;  // Next byte needs a gap cycle
      @(negedge clk_48mhz_i);
    end
    @(posedge clk_48mhz_i);
    tx_pkt_end_i <= 1'b1;     // CRC and EOP done
    @(posedge clk_48mhz_i);
    tx_pkt_end_i <= 1'b0;
    assert (byte_cnt == model_len[exp_ep]) else begin
      $display("ERR %0t tx_data_get_i count got %0d exp %0d", $time, byte_cnt,
               model_len[exp_ep]);
      errors++;
    end
  endtask

`endif

/* tb_usb_in.sv */
/* Testbench for the USB IN path
   Drives tokens, handshakes and buffer loads, predicts every response
   and checks PIDs, payload bytes, toggles and events */

`timescale 1ns/10ps
`default_nettype none

module tb_usb_in;

  localparam usb_in_pkg::dev_addr_t DEV_ADDR = 7'h2a;
  localparam int NUM_TESTS = 6;

  // DUT ports
  logic                   clk_48mhz_i = 1'b0;
  logic                   rst_ni;
  logic                   link_reset_i;
  usb_in_pkg::dev_addr_t  dev_addr_i, rx_addr_i;
  logic                   rx_pkt_start_i, rx_pkt_end_i, rx_pkt_valid_i;
  usb_in_pkg::pid_t       rx_pid_i, tx_pid_o;
  usb_in_pkg::ep_num_t    rx_endp_i;
  logic                   tx_pkt_start_o, tx_pkt_end_i, tx_data_avail_o, tx_data_get_i;
  logic [7:0]             tx_data_o, wr_data_i;
  usb_in_pkg::ep_mask_t   in_data_toggle_o, in_sent_o, ep_enable_i, ep_stall_i;
  logic                   event_timeout_o, event_nak_o;
  logic                   wr_en_i, set_ready_i;
  usb_in_pkg::ep_idx_t    wr_ep_i, set_ep_i;
  usb_in_pkg::pkt_addr_t  wr_addr_i;
  usb_in_pkg::pkt_len_t   set_len_i;

  // Reference model of the loaded packets and toggles
  logic [7:0]             model_mem [usb_in_pkg::NUM_IN_EPS][usb_in_pkg::MAX_PKT_BYTES];
  int                     model_len [usb_in_pkg::NUM_IN_EPS];
  usb_in_pkg::ep_mask_t   model_ready = '0;
  usb_in_pkg::ep_mask_t   model_toggle = '0;
  usb_in_pkg::ep_mask_t   sent_seen = '0;  // in_sent_o bits since last clear
  int exp_pid = -1;  // -1 means no response allowed
  int exp_ep = 0;
  int byte_cnt = 0;
  int errors = 0;
  int err_start = 0;
  int tests_failed = 0;
  int nak_cnt = 0;
  int cycles = 0;
  int budget = 100;  // Reset and setup share that the tests add to

  usb_in_top dut_i (.*);

  always #5 clk_48mhz_i = ~clk_48mhz_i;  // 10 ns period

  // Expected answer to an IN token from the model state only
  function automatic int predict_response(input usb_in_pkg::dev_addr_t addr,
                                          input usb_in_pkg::ep_num_t endp);
    if (addr != DEV_ADDR || endp >= usb_in_pkg::NUM_IN_EPS) return -1;
    if (!ep_enable_i[endp]) return -1;                        // Disabled is silent
    if (ep_stall_i[endp]) return int'(usb_in_pkg::PID_STALL);
    if (!model_ready[endp]) return int'(usb_in_pkg::PID_NAK);
    return model_toggle[endp] ? int'(usb_in_pkg::PID_DATA1) : int'(usb_in_pkg::PID_DATA0);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checker sampling on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_48mhz_i) begin
    if (rst_ni) begin
      if (tx_pkt_start_o) begin
        assert (exp_pid >= 0) else begin
          $display("%0t packet start where the DUT had to stay silent", $time);
          errors++;
        end
        if (exp_pid >= 0) begin
          assert (int'(tx_pid_o) == exp_pid) else begin
            $display("ERR %0t tx_pid_o got %h exp %h", $time, tx_pid_o, exp_pid[3:0]);
            errors++;
          end
        end
      end
      if (tx_data_get_i) begin
        assert (byte_cnt < model_len[exp_ep]) else begin
          $display("%0t byte taken past the end of the packet", $time);
          errors++;
        end
        if (byte_cnt < model_len[exp_ep]) begin
          assert (tx_data_o == model_mem[exp_ep][byte_cnt]) else begin
            $display("ERR %0t tx_data_o got %h exp %h", $time, tx_data_o,
                     model_mem[exp_ep][byte_cnt]);
            errors++;
          end
        end
        byte_cnt++;
      end
      if (event_nak_o) nak_cnt++;
      sent_seen |= in_sent_o;
    end
  end

  // Watchdog whose budget grows with every test
  initial begin
    while (cycles <= budget) begin
      @(posedge clk_48mhz_i);
      cycles++;
    end
    $display("Watchdog expired after %0d cycles, the sequence did not finish", cycles);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequence helpers
  ////////////////////////////////////////////////////////////////////////////

  // Software fills the buffer with random bytes and marks it ready
  task automatic load_packet(input int ep, input int len);
    for (int i = 0; i < len; i++) begin
      @(posedge clk_48mhz_i);
      model_mem[ep][i] = 8'($urandom);
      wr_en_i   <= 1'b1;
      wr_ep_i   <= usb_in_pkg::ep_idx_t'(ep);
      wr_addr_i <= usb_in_pkg::pkt_addr_t'(i);
      wr_data_i <= model_mem[ep][i];
    end
    @(posedge clk_48mhz_i);
    wr_en_i     <= 1'b0;
    set_ready_i <= 1'b1;
    set_ep_i    <= usb_in_pkg::ep_idx_t'(ep);
    set_len_i   <= usb_in_pkg::pkt_len_t'(len);
    @(posedge clk_48mhz_i);
    set_ready_i     <= 1'b0;
    model_ready[ep] = 1'b1;
    model_len[ep]   = len;
    budget += len * 4;
  endtask

  // Waits for tx_pkt_start_o on falling edges
  task automatic wait_start(input int max_cycles, output bit seen);
    seen = 1'b0;
    for (int n = 0; n < max_cycles && !seen; n++) begin
      @(negedge clk_48mhz_i);
      seen = tx_pkt_start_o;
    end
  endtask

  // IN token then a response one cycle later or silence for 20 cycles
  task automatic issue_in(input usb_in_pkg::dev_addr_t addr, input usb_in_pkg::ep_num_t endp);
    bit seen;
    exp_pid  = predict_response(addr, endp);
    exp_ep   = (endp < usb_in_pkg::NUM_IN_EPS) ? int'(endp) : 0;
    byte_cnt = 0;
    send_token(usb_in_pkg::PID_IN, addr, endp);
    wait_start(exp_pid < 0 ? 20 : 1, seen);
    assert (seen || exp_pid < 0) else begin
      $display("%0t no response to an IN token for endpoint %0d", $time, endp);
      errors++;
    end
    if (seen && (exp_pid == int'(usb_in_pkg::PID_DATA0) ||
                 exp_pid == int'(usb_in_pkg::PID_DATA1))) consume_packet();
  endtask

  task automatic check_toggles();
    @(negedge clk_48mhz_i);
    assert (in_data_toggle_o == model_toggle) else begin
      $display("ERR %0t in_data_toggle_o got %b exp %b", $time, in_data_toggle_o, model_toggle);
      errors++;
    end
  endtask

  // Host ACK then the in_sent_o pulse and the flipped toggle
  task automatic ack_and_check(input int ep);
    usb_in_pkg::ep_mask_t exp_mask;
    exp_mask  = usb_in_pkg::ep_mask_t'(1) << ep;
    sent_seen = '0;
    send_handshake(usb_in_pkg::PID_ACK);
    model_ready[ep]  = 1'b0;
    model_toggle[ep] = ~model_toggle[ep];
    repeat (2) @(negedge clk_48mhz_i);
    assert (sent_seen == exp_mask) else begin
      $display("ERR %0t in_sent_o got %b exp %b", $time, sent_seen, exp_mask);
      errors++;
    end
    check_toggles();
  endtask

  // Timeout strobe exactly ACK_TIMEOUT_CYCLES+1 cycles after the packet end
  task automatic wait_timeout();
    int n;
    bit seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < usb_in_pkg::ACK_TIMEOUT_CYCLES + 20) begin
      @(negedge clk_48mhz_i);
      n++;
      seen = event_timeout_o;
    end
    assert (seen && n == usb_in_pkg::ACK_TIMEOUT_CYCLES + 1) else begin
      $display("%0t handshake timeout seen %0b after %0d cycles, expected after %0d",
               $time, seen, n, usb_in_pkg::ACK_TIMEOUT_CYCLES + 1);
      errors++;
    end
  endtask

  task automatic begin_test();
    err_start = errors;
    budget += 200;
  endtask

  task automatic end_test(input int num, input string name);
    if (errors == err_start) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      $display("test %0d %s: FAIL", num, name);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int len;
    int naks;
    void'($urandom(57488));
    rst_ni         = 1'b0;
    link_reset_i   = 1'b0;
    dev_addr_i     = DEV_ADDR;
    rx_pkt_start_i = 1'b0;
    rx_pkt_end_i   = 1'b0;
    rx_pkt_valid_i = 1'b0;
    rx_pid_i       = '0;
    rx_addr_i      = '0;
    rx_endp_i      = '0;
    tx_pkt_end_i   = 1'b0;
    tx_data_get_i  = 1'b0;
    wr_en_i        = 1'b0;
    wr_ep_i        = '0;
    wr_addr_i      = '0;
    wr_data_i      = '0;
    set_ready_i    = 1'b0;
    set_ep_i       = '0;
    set_len_i      = '0;
    ep_enable_i    = '0;
    ep_stall_i     = '0;
    repeat (3) @(posedge clk_48mhz_i);
    rst_ni <= 1'b1;
    @(posedge clk_48mhz_i);
    ep_enable_i <= 4'b0111;  // Endpoint 3 stays disabled
    repeat (2) @(posedge clk_48mhz_i);

    begin_test();
    issue_in(DEV_ADDR, 4'd1);
    check_toggles();
    end_test(1, "nak on empty endpoint");

    begin_test();
    len = $urandom_range(16, 1);
    load_packet(0, len);
    issue_in(DEV_ADDR, 4'd0);  // DATA0
    ack_and_check(0);
    load_packet(0, $urandom_range(16, 1));
    issue_in(DEV_ADDR, 4'd0);  // DATA1
    ack_and_check(0);
    end_test(2, "data and ack");

    begin_test();
    load_packet(1, $urandom_range(16, 1));
    issue_in(DEV_ADDR, 4'd1);
    wait_timeout();
    issue_in(DEV_ADDR, 4'd1);  // Same PID and bytes again
    naks = nak_cnt;
    send_handshake(usb_in_pkg::PID_NAK);
    @(negedge clk_48mhz_i);
    assert (nak_cnt == naks + 1) else begin
      $display("%0t host NAK gave %0d event_nak_o pulses", $time, nak_cnt - naks);
      errors++;
    end
    issue_in(DEV_ADDR, 4'd1);
    ack_and_check(1);
    end_test(3, "timeout and nak retry");

    begin_test();
    load_packet(2, $urandom_range(16, 1));
    @(posedge clk_48mhz_i);
    ep_stall_i <= 4'b0100;
    repeat (2) @(posedge clk_48mhz_i);
    issue_in(DEV_ADDR, 4'd2);  // STALL despite data
    send_token(usb_in_pkg::PID_SETUP, DEV_ADDR, 4'd2);
    model_toggle[2] = 1'b1;
    check_toggles();
    @(posedge clk_48mhz_i);
    ep_stall_i <= '0;
    repeat (2) @(posedge clk_48mhz_i);
    issue_in(DEV_ADDR, 4'd2);  // DATA1 after SETUP
    ack_and_check(2);
    end_test(4, "stall and setup");

    begin_test();
    issue_in(DEV_ADDR ^ 7'h01, 4'd0);
    issue_in(DEV_ADDR, 4'd3);
    issue_in(DEV_ADDR, 4'd6);
    end_test(5, "ignored tokens");

    begin_test();
    @(posedge clk_48mhz_i);
    link_reset_i <= 1'b1;
    @(posedge clk_48mhz_i);
    link_reset_i <= 1'b0;
    model_toggle = '0;
    check_toggles();
    load_packet(1, 0);
    issue_in(DEV_ADDR, 4'd1);  // Zero length DATA0
    ack_and_check(1);
    end_test(6, "link reset and zero length");

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             NUM_TESTS, NUM_TESTS - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  `include "tb_usb_in_host.svh"

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
usb_in_pkg.sv
usb_rx_pkt_if.sv
usb_in_ep_if.sv
usb_in_pe.sv
usb_in_ep_buf.sv
usb_in_top.sv
tb_usb_in.sv
